// File: safety_island_config.svh
/*
  Address map and sizing of the safety island memory side.
  Both banks sit at address 0 and take 2 * SI_BANK_NUM_BYTES.
  Peripheral slots are SI_PERIPH_SLOT_BYTES wide and must be a power of two.
  SI_BOOTROM_WORDS must be a power of two, because the ROM index wraps.
*/
`ifndef SAFETY_ISLAND_CONFIG_SVH
`define SAFETY_ISLAND_CONFIG_SVH

// ----------------------------------------
// Bus widths
// ----------------------------------------
`define SI_ADDR_WIDTH 32
`define SI_DATA_WIDTH 32

// ----------------------------------------
// Address map
// ----------------------------------------
`define SI_BANK_NUM_BYTES 4096
`define SI_PERIPH_OFFSET 32'h0020_0000
`define SI_ADDR_RANGE 32'h0080_0000
// Slot 0 SoC control, slot 1 boot ROM, rest error target
`define SI_PERIPH_SLOT_BYTES 32'h0000_1000

// ----------------------------------------
// Peripheral contents
// ----------------------------------------
`define SI_BOOTROM_WORDS 8
`define SI_ERROR_WORD 32'hBADC_AB1E
// Boot ROM base plus 0x80
`define SI_BOOT_ADDR_DEFAULT (`SI_PERIPH_OFFSET + `SI_PERIPH_SLOT_BYTES + 32'h80)

`endif

// File: safety_island_pkg.sv
/*
  Shared types of the safety island memory side.
  The address union assumes the island spans SI_ADDR_RANGE from address 0.
  Boot ROM contents are fixed here and read by both RTL and testbench.
*/
`include "safety_island_config.svh"

package safety_island_pkg;

  // ----------------------------------------
  // Address field widths
  // ----------------------------------------
  localparam int unsigned BankWordIdxW = $clog2(`SI_BANK_NUM_BYTES) - 2;
  localparam int unsigned BankUpperW   = `SI_ADDR_WIDTH - BankWordIdxW - 3;
  localparam int unsigned SlotLsb      = $clog2(`SI_PERIPH_SLOT_BYTES);
  localparam int unsigned RegIdxW      = SlotLsb - 2;
  localparam int unsigned SlotW        = $clog2(`SI_ADDR_RANGE) - SlotLsb;
  localparam int unsigned PeriphUpperW = `SI_ADDR_WIDTH - SlotW - SlotLsb;
  localparam int unsigned BootRomIdxW  = $clog2(`SI_BOOTROM_WORDS);

  // Bus request, one per clock
  typedef struct packed {
    logic                      req;
    logic                      we;
    logic [3:0]                be;
    logic [`SI_ADDR_WIDTH-1:0] addr;
    logic [`SI_DATA_WIDTH-1:0] wdata;
  } si_req_t;

  typedef enum logic [2:0] {
    TGT_BANK0,
    TGT_BANK1,
    TGT_SOC_CTRL,
    TGT_BOOTROM,
    TGT_ERROR
  } si_target_e;

  // Same address word, seen by the bank and by the peripheral decoder
  typedef union packed {
    struct packed {
      logic [BankUpperW-1:0]   upper;
      logic                    bank_sel;
      logic [BankWordIdxW-1:0] word_idx;
      logic [1:0]              byte_off;
    } bank;
    struct packed {
      logic [PeriphUpperW-1:0] upper;
      logic [SlotW-1:0]        slot;
      logic [RegIdxW-1:0]      reg_idx;
      logic [1:0]              byte_off;
    } periph;
  } si_addr_u;

  // Stage 1 to stage 2 item, req.req is the valid bit
  typedef struct packed {
    si_req_t    req;
    si_target_e tgt;
  } si_stage_t;

  typedef enum logic [1:0] {
    BOOT_DEFAULT,
    BOOT_JTAG,
    BOOT_PRELOADED
  } si_bootmode_e;

  // Small boot stub: spin on fetch enable, then jump to bank 0
  localparam logic [`SI_DATA_WIDTH-1:0] BOOT_ROM [`SI_BOOTROM_WORDS] = '{
    32'h0020_02b7,
    32'h0042_a303,
    32'hfe03_0ee3,
    32'h0000_0393,
    32'h0003_8067,
    32'h0000_0013,
    32'h0000_0013,
    32'h0010_0073
  };

endpackage

// File: si_addr_decode.sv
/*
  Stage 1 of the access pipeline.
  Every request is accepted, there is no back-pressure.
  Out-of-map addresses go to the error target instead of an external port.
*/
`timescale 1ns/100ps
`include "safety_island_config.svh"

module si_addr_decode (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  safety_island_pkg::si_req_t   req_i,
  output safety_island_pkg::si_stage_t stage_o
);

  // Absolute slot numbers of the two real peripherals
  localparam logic [safety_island_pkg::SlotW-1:0] SocCtrlSlot =
    safety_island_pkg::SlotW'(`SI_PERIPH_OFFSET / `SI_PERIPH_SLOT_BYTES);
  localparam logic [safety_island_pkg::SlotW-1:0] BootRomSlot = SocCtrlSlot + 1'b1;

  safety_island_pkg::si_addr_u   addr_view;
  safety_island_pkg::si_target_e tgt_d;
  safety_island_pkg::si_stage_t  stage_q;
  logic                          valid_q;

  assign addr_view = req_i.addr;

  // ----------------------------------------
  // Target decode
  // ----------------------------------------
  always_comb begin
    tgt_d = safety_island_pkg::TGT_ERROR;
    if (addr_view.bank.upper == '0) begin
      // Below twice the bank size
      tgt_d = addr_view.bank.bank_sel ? safety_island_pkg::TGT_BANK1
                                      : safety_island_pkg::TGT_BANK0;
    end else if (addr_view.periph.upper == '0 && req_i.addr >= `SI_PERIPH_OFFSET) begin
      if (addr_view.periph.slot == SocCtrlSlot) begin
        tgt_d = safety_island_pkg::TGT_SOC_CTRL;
      end else if (addr_view.periph.slot == BootRomSlot) begin
        tgt_d = safety_island_pkg::TGT_BOOTROM;
      end
    end
  end

  // ----------------------------------------
  // Stage register
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i.req;
    end
  end

  // Payload only moves with a request
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      stage_q.req <= req_i;
      stage_q.tgt <= tgt_d;
    end
  end

  always_comb begin
    stage_o         = stage_q;
    stage_o.req.req = valid_q;
  end

  // A valid item never carries an undefined target code
  a_legal_target : assert property (@(posedge clk_i) disable iff (!rst_ni)
    stage_o.req.req |-> stage_o.tgt inside {safety_island_pkg::TGT_BANK0,
                                            safety_island_pkg::TGT_BANK1,
                                            safety_island_pkg::TGT_SOC_CTRL,
                                            safety_island_pkg::TGT_BOOTROM,
                                            safety_island_pkg::TGT_ERROR})
    else $error("Stage 1 produced an illegal target %0d", stage_o.tgt);

endmodule

// File: si_mem_bank.sv
/*
  Single-port word SRAM bank with byte enables.
  Read data appears one cycle after an enabled read and holds until the next.
  Read data of a write cycle is not updated. Contents are not reset.
*/
`timescale 1ns/100ps
`include "safety_island_config.svh"

module si_mem_bank (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         en_i,
  input  logic                                         we_i,
  input  logic [3:0]                                   be_i,
  input  logic [safety_island_pkg::BankWordIdxW-1:0]   word_addr_i,
  input  logic [`SI_DATA_WIDTH-1:0]                    wdata_i,
  output logic [`SI_DATA_WIDTH-1:0]                    rdata_o
);

  localparam int unsigned NumWords = `SI_BANK_NUM_BYTES / 4;

  logic [`SI_DATA_WIDTH-1:0] mem_q [NumWords];
  logic [`SI_DATA_WIDTH-1:0] rdata_q;

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        // Only the enabled byte lanes change
        for (int unsigned b = 0; b < 4; b++) begin
          if (be_i[b]) begin
            mem_q[word_addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[word_addr_i];
      end
    end
  end

  assign rdata_o = rdata_q;

  // A write without any byte lane is a master bug
  a_write_has_bytes : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (en_i && we_i) |-> (be_i != '0))
    else $error("Bank write with no byte enabled at word %0d", word_addr_i);

endmodule

// File: si_periph_block.sv
/*
  Peripheral region: SoC control registers, boot ROM and error target.
  Boot mode is sampled once, in the first cycle after reset; that capture
  also wins over a software write to fetch enable in the same cycle.
  Read data is registered and only valid one cycle after a read.
*/
`timescale 1ns/100ps
`include "safety_island_config.svh"

module si_periph_block (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  safety_island_pkg::si_stage_t    req_i,
  input  safety_island_pkg::si_bootmode_e bootmode_i,
  input  logic                            fetch_enable_i,
  output logic [`SI_DATA_WIDTH-1:0]       rdata_o,
  output logic                            fetch_enable_o,
  output logic [`SI_ADDR_WIDTH-1:0]       boot_addr_o
);

  // SoC control word map
  localparam logic [safety_island_pkg::RegIdxW-1:0] RegBootAddr = 'd0;
  localparam logic [safety_island_pkg::RegIdxW-1:0] RegFetchEn  = 'd1;
  localparam logic [safety_island_pkg::RegIdxW-1:0] RegBootMode = 'd2;

  safety_island_pkg::si_addr_u      addr_view;
  safety_island_pkg::si_bootmode_e  bootmode_q;
  logic [`SI_ADDR_WIDTH-1:0]        boot_addr_q;
  logic                             fetchen_q;
  logic                             first_cycle_q;
  logic                             soc_we;
  logic                             rd_en;
  logic [`SI_DATA_WIDTH-1:0]        rdata_d;
  logic [`SI_DATA_WIDTH-1:0]        rdata_q;

  assign addr_view = req_i.req.addr;

  assign soc_we = req_i.req.req && req_i.req.we
                  && req_i.tgt == safety_island_pkg::TGT_SOC_CTRL;
  assign rd_en  = req_i.req.req && !req_i.req.we;

  // ----------------------------------------
  // SoC control registers
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_cycle_q <= 1'b1;
    end else begin
      first_cycle_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      boot_addr_q <= `SI_BOOT_ADDR_DEFAULT;
    end else if (soc_we && addr_view.periph.reg_idx == RegBootAddr) begin
      for (int unsigned b = 0; b < 4; b++) begin
        if (req_i.req.be[b]) begin
          boot_addr_q[8*b +: 8] <= req_i.req.wdata[8*b +: 8];
        end
      end
    end
  end

  // Strap capture first, software after that
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetchen_q  <= 1'b0;
      bootmode_q <= safety_island_pkg::BOOT_DEFAULT;
    end else if (first_cycle_q) begin
      bootmode_q <= bootmode_i;
      fetchen_q  <= (bootmode_i == safety_island_pkg::BOOT_JTAG);
    end else if (soc_we && addr_view.periph.reg_idx == RegFetchEn && req_i.req.be[0]) begin
      fetchen_q <= req_i.req.wdata[0];
    end
  end

  assign fetch_enable_o = fetchen_q | fetch_enable_i;
  assign boot_addr_o    = boot_addr_q;

  // ----------------------------------------
  // Read path
  // ----------------------------------------
  always_comb begin
    rdata_d = '0;
    case (req_i.tgt)
      safety_island_pkg::TGT_SOC_CTRL: begin
        case (addr_view.periph.reg_idx)
          RegBootAddr: rdata_d = boot_addr_q;
          RegFetchEn:  rdata_d = {{(`SI_DATA_WIDTH-1){1'b0}}, fetchen_q};
          RegBootMode: rdata_d = {{(`SI_DATA_WIDTH-2){1'b0}}, bootmode_q};
          default:     rdata_d = '0;
        endcase
      end
      safety_island_pkg::TGT_BOOTROM: begin
        // Index wraps inside the slot
        rdata_d = safety_island_pkg::BOOT_ROM[
          addr_view.periph.reg_idx[safety_island_pkg::BootRomIdxW-1:0]];
      end
      default: rdata_d = `SI_ERROR_WORD;
    endcase
  end

  // Writes to ROM and error target fall through here untouched
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: si_access_stage.sv
/*
  Stage 2 of the access pipeline.
  One cycle from a valid stage item to rvalid_o, for reads and writes.
  rdata_o is only meaningful for reads while rvalid_o is high.
*/
`timescale 1ns/100ps
`include "safety_island_config.svh"

module si_access_stage (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  safety_island_pkg::si_stage_t    stage_i,
  input  safety_island_pkg::si_bootmode_e bootmode_i,
  input  logic                            fetch_enable_i,
  output logic [`SI_DATA_WIDTH-1:0]       rdata_o,
  output logic                            rvalid_o,
  output logic                            fetch_enable_o,
  output logic [`SI_ADDR_WIDTH-1:0]       boot_addr_o
);

  safety_island_pkg::si_addr_u   addr_view;
  safety_island_pkg::si_stage_t  periph_req;
  safety_island_pkg::si_target_e tgt_q;
  logic                          bank0_en;
  logic                          bank1_en;
  logic                          rvalid_q;
  logic [`SI_DATA_WIDTH-1:0]     bank0_rdata;
  logic [`SI_DATA_WIDTH-1:0]     bank1_rdata;
  logic [`SI_DATA_WIDTH-1:0]     periph_rdata;

  assign addr_view = stage_i.req.addr;

  // ----------------------------------------
  // Target enables
  // ----------------------------------------
  assign bank0_en = stage_i.req.req && stage_i.tgt == safety_island_pkg::TGT_BANK0;
  assign bank1_en = stage_i.req.req && stage_i.tgt == safety_island_pkg::TGT_BANK1;

  always_comb begin
    periph_req         = stage_i;
    periph_req.req.req = stage_i.req.req && !bank0_en && !bank1_en;
  end

  si_mem_bank i_bank0 (
    .clk_i,
    .rst_ni,
    .en_i        ( bank0_en                   ),
    .we_i        ( stage_i.req.we             ),
    .be_i        ( stage_i.req.be             ),
    .word_addr_i ( addr_view.bank.word_idx    ),
    .wdata_i     ( stage_i.req.wdata          ),
    .rdata_o     ( bank0_rdata                )
  );

  si_mem_bank i_bank1 (
    .clk_i,
    .rst_ni,
    .en_i        ( bank1_en                   ),
    .we_i        ( stage_i.req.we             ),
    .be_i        ( stage_i.req.be             ),
    .word_addr_i ( addr_view.bank.word_idx    ),
    .wdata_i     ( stage_i.req.wdata          ),
    .rdata_o     ( bank1_rdata                )
  );

  si_periph_block i_periph_block (
    .clk_i,
    .rst_ni,
    .req_i          ( periph_req     ),
    .bootmode_i,
    .fetch_enable_i,
    .rdata_o        ( periph_rdata   ),
    .fetch_enable_o,
    .boot_addr_o
  );

  // ----------------------------------------
  // Response
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      tgt_q    <= safety_island_pkg::TGT_ERROR;
    end else begin
      rvalid_q <= stage_i.req.req;
      if (stage_i.req.req) begin
        tgt_q <= stage_i.tgt;
      end
    end
  end

  // Registered target lines up with the one-cycle target data
  always_comb begin
    case (tgt_q)
      safety_island_pkg::TGT_BANK0: rdata_o = bank0_rdata;
      safety_island_pkg::TGT_BANK1: rdata_o = bank1_rdata;
      default:                      rdata_o = periph_rdata;
    endcase
  end

  assign rvalid_o = rvalid_q;

  // Exactly one response per item, one cycle later
  a_rvalid_latency : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_o == $past(stage_i.req.req))
    else $error("rvalid_o does not follow the stage item by one cycle");

endmodule

// File: safety_island_top.sv
/*
  Memory side of the safety island: decode stage and access stage.
  One request per clock, always accepted; response two cycles later.
  There is no error bit, unmapped addresses read the error word.
*/
`timescale 1ns/100ps
`include "safety_island_config.svh"

module safety_island_top (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  safety_island_pkg::si_req_t      req_i,
  input  safety_island_pkg::si_bootmode_e bootmode_i,
  input  logic                            fetch_enable_i,
  output logic [`SI_DATA_WIDTH-1:0]       rdata_o,
  output logic                            rvalid_o,
  output logic                            fetch_enable_o,
  output logic [`SI_ADDR_WIDTH-1:0]       boot_addr_o
);

  // Item between the two stages
  safety_island_pkg::si_stage_t stage;

  si_addr_decode i_addr_decode (
    .clk_i,
    .rst_ni,
    .req_i,
    .stage_o ( stage )
  );

  si_access_stage i_access_stage (
    .clk_i,
    .rst_ni,
    .stage_i        ( stage ),
    .bootmode_i,
    .fetch_enable_i,
    .rdata_o,
    .rvalid_o,
    .fetch_enable_o,
    .boot_addr_o
  );

endmodule

// File: tb_safety_island.sv
/*
  Testbench of the safety island memory side.
  Bank words are always written in full before any partial write or read,
  since bank contents power up unknown. Stops at the first mismatch.
  Bank model contents survive a reset, as the SRAM banks do.
*/
`timescale 1ns/100ps
`include "safety_island_config.svh"

module tb_safety_island;

  localparam int unsigned NumBankWords = 6;
  localparam int unsigned NumRomReads  = 10;
  localparam int unsigned NumBurst     = 16;
  // Banks, ROM, boot regs, error target, burst, boot straps
  localparam int unsigned NumRequests  =
    6 * NumBankWords + NumRomReads + 2 + 7 + 6 + NumBurst + 4;
  // Three resets and eight pipeline drains, each a few cycles
  localparam int unsigned NumIdlePhases = 3 + 8;
  localparam int unsigned TimeoutCycles = NumRequests + 4 * NumIdlePhases + 50;
  localparam logic [31:0] SocBase = `SI_PERIPH_OFFSET;
  localparam logic [31:0] RomBase = `SI_PERIPH_OFFSET + `SI_PERIPH_SLOT_BYTES;
  localparam logic [31:0] UnusedSlot = `SI_PERIPH_OFFSET + 5 * `SI_PERIPH_SLOT_BYTES + 32'h10;

  typedef struct packed {
    logic        is_read;
    logic [31:0] data;
  } exp_item_t;

  logic                            clk_i = 1'b0;
  logic                            rst_ni;
  safety_island_pkg::si_req_t      req_i;
  safety_island_pkg::si_bootmode_e bootmode_i;
  logic                            fetch_enable_i;
  logic [`SI_DATA_WIDTH-1:0]       rdata_o;
  logic                            rvalid_o;
  logic                            fetch_enable_o;
  logic [`SI_ADDR_WIDTH-1:0]       boot_addr_o;

  // Reference model state
  logic [31:0] bank0_m [`SI_BANK_NUM_BYTES/4];
  logic [31:0] bank1_m [`SI_BANK_NUM_BYTES/4];
  logic [31:0] boot_addr_m;
  logic        fetchen_m;
  logic [1:0]  bootmode_m;

  exp_item_t   exp_q [$];
  exp_item_t   resp_item;
  logic [1:0]  req_hist;
  logic [15:0] lfsr_q = 16'd97;
  int unsigned cycle_cnt = 0;
  int unsigned idx [NumBankWords];

  always #10 clk_i = ~clk_i;

  safety_island_top i_safety_island_top (
    .clk_i,
    .rst_ni,
    .req_i,
    .bootmode_i,
    .fetch_enable_i,
    .rdata_o,
    .rvalid_o,
    .fetch_enable_o,
    .boot_addr_o
  );

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  // Taps 16, 14, 13, 11; one step per bit
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    logic        fb;
    int unsigned i;
    val = '0;
    for (i = 0; i < n; i++) begin
      fb     = lfsr_q[0] ^ lfsr_q[2] ^ lfsr_q[3] ^ lfsr_q[5];
      lfsr_q = {fb, lfsr_q[15:1]};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                              input logic [31:0] new_val,
                                              input logic [3:0]  be);
    logic [31:0] res;
    int unsigned b;
    res = old_val;
    for (b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = new_val[8*b +: 8];
    end
    return res;
  endfunction

  function automatic logic [31:0] bank_addr(input int unsigned bank, input int unsigned widx);
    return bank * `SI_BANK_NUM_BYTES + widx * 4;
  endfunction

  // Expected read data from the address map; updates the model on writes
  function automatic logic [31:0] model_access(input logic we, input logic [3:0] be,
                                               input logic [31:0] addr,
                                               input logic [31:0] wdata);
    int unsigned widx;
    int unsigned slot;
    logic [31:0] res;
    res = `SI_ERROR_WORD;
    if (addr < 2 * `SI_BANK_NUM_BYTES) begin
      widx = (addr % `SI_BANK_NUM_BYTES) / 4;
      if (addr < `SI_BANK_NUM_BYTES) begin
        res = bank0_m[widx];
        if (we) bank0_m[widx] = merge_bytes(res, wdata, be);
      end else begin
        res = bank1_m[widx];
        if (we) bank1_m[widx] = merge_bytes(res, wdata, be);
      end
    end else if (addr >= `SI_PERIPH_OFFSET && addr < `SI_ADDR_RANGE) begin
      slot = (addr - `SI_PERIPH_OFFSET) / `SI_PERIPH_SLOT_BYTES;
      widx = (addr % `SI_PERIPH_SLOT_BYTES) / 4;
      if (slot == 0) begin
        case (widx)
          0: begin
            res = boot_addr_m;
            if (we) boot_addr_m = merge_bytes(res, wdata, be);
          end
          1: begin
            res = {31'b0, fetchen_m};
            if (we && be[0]) fetchen_m = wdata[0];
          end
          2:       res = {30'b0, bootmode_m};
          default: res = '0;
        endcase
      end else if (slot == 1) begin
        res = safety_island_pkg::BOOT_ROM[widx % `SI_BOOTROM_WORDS];
      end
    end
    return res;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("Something failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic issue(input logic we, input logic [3:0] be, input logic [31:0] addr,
                       input logic [31:0] wdata);
    safety_island_pkg::si_req_t r;
    exp_item_t                  item;
    r.req        = 1'b1;
    r.we         = we;
    r.be         = be;
    r.addr       = addr;
    r.wdata      = wdata;
    item.is_read = !we;
    item.data    = model_access(we, be, addr, wdata);
    @(posedge clk_i);
    req_i <= r;
    exp_q.push_back(item);
  endtask

  // Stop issuing and wait until every response came back
  task automatic drain();
    @(posedge clk_i);
    req_i.req <= 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
  endtask

  task automatic apply_reset(input safety_island_pkg::si_bootmode_e mode);
    @(posedge clk_i);
    rst_ni     <= 1'b0;
    bootmode_i <= mode;
    req_i.req  <= 1'b0;
    repeat (2) @(posedge clk_i);
    rst_ni      <= 1'b1;
    boot_addr_m = `SI_BOOT_ADDR_DEFAULT;
    bootmode_m  = mode;
    fetchen_m   = (mode == safety_island_pkg::BOOT_JTAG);
  endtask

  // ----------------------------------------
  // Test sequences
  // ----------------------------------------
  task automatic exercise_boot_regs();
    logic [31:0] rnd;
    check_value("boot_addr_o", boot_addr_o, `SI_BOOT_ADDR_DEFAULT);
    rnd = rand_bits(32);
    issue(1'b0, 4'hF, SocBase, '0);
    issue(1'b1, 4'hF, SocBase, rnd);
    issue(1'b1, 4'h1, SocBase + 4, 32'h1);
    issue(1'b0, 4'hF, SocBase, '0);
    issue(1'b0, 4'hF, SocBase + 4, '0);
    drain();
    check_value("boot_addr_o", boot_addr_o, boot_addr_m);
    check_value("fetch_enable_o", {31'b0, fetch_enable_o}, 32'h1);
    issue(1'b1, 4'h1, SocBase + 4, 32'h0);
    issue(1'b0, 4'hF, SocBase + 4, '0);
    drain();
    check_value("fetch_enable_o", {31'b0, fetch_enable_o}, 32'h0);
    // External enable alone still starts the core
    @(posedge clk_i);
    fetch_enable_i <= 1'b1;
    @(negedge clk_i);
    check_value("fetch_enable_o", {31'b0, fetch_enable_o}, 32'h1);
    @(posedge clk_i);
    fetch_enable_i <= 1'b0;
  endtask

  // Same word index in both banks, different data
  task automatic run_bank_traffic();
    logic [31:0] rnd;
    logic [3:0]  be;
    int unsigned i;
    int unsigned b;
    for (i = 0; i < NumBankWords; i++) begin
      idx[i] = rand_bits(safety_island_pkg::BankWordIdxW);
    end
    for (i = 0; i < NumBankWords; i++) begin
      for (b = 0; b < 2; b++) begin
        rnd = rand_bits(32);
        issue(1'b1, 4'hF, bank_addr(b, idx[i]), rnd);
      end
    end
    for (i = 0; i < NumBankWords; i++) begin
      for (b = 0; b < 2; b++) begin
        rnd = rand_bits(4);
        be  = (rnd[3:0] == 4'h0) ? 4'h1 : rnd[3:0];
        rnd = rand_bits(32);
        issue(1'b1, be, bank_addr(b, idx[i]), rnd);
      end
    end
    for (i = 0; i < NumBankWords; i++) begin
      for (b = 0; b < 2; b++) begin
        issue(1'b0, 4'hF, bank_addr(b, idx[i]), '0);
      end
    end
    drain();
  endtask

  task automatic read_boot_rom();
    logic [31:0] rnd;
    int unsigned i;
    // Past the ROM depth to see the index wrap
    for (i = 0; i < NumRomReads; i++) begin
      issue(1'b0, 4'hF, RomBase + i * 4, '0);
    end
    rnd = rand_bits(32);
    issue(1'b1, 4'hF, RomBase + 12, rnd);
    issue(1'b0, 4'hF, RomBase + 12, '0);
    drain();
  endtask

  task automatic probe_error_target();
    logic [31:0] rnd;
    rnd = rand_bits(32);
    issue(1'b0, 4'hF, UnusedSlot, '0);
    issue(1'b0, 4'hF, 32'h0010_0000, '0);
    issue(1'b0, 4'hF, 2 * `SI_BANK_NUM_BYTES, '0);
    issue(1'b0, 4'hF, `SI_ADDR_RANGE + 32'h40, '0);
    issue(1'b1, 4'hF, UnusedSlot, rnd);
    issue(1'b0, 4'hF, UnusedSlot, '0);
    drain();
  endtask

  // One request per cycle, target picked at random
  task automatic run_mixed_burst();
    logic [31:0] rnd;
    int unsigned sel;
    int unsigned i;
    for (i = 0; i < NumBurst; i++) begin
      sel = rand_bits(3);
      rnd = rand_bits(32);
      case (sel)
        0, 1:    issue(1'b0, 4'hF, bank_addr(sel, idx[i % NumBankWords]), '0);
        2, 3:    issue(1'b1, 4'b0001 << (i % 4), bank_addr(sel - 2, idx[i % NumBankWords]), rnd);
        4:       issue(1'b0, 4'hF, RomBase + (rnd % 8) * 4, '0);
        5:       issue(1'b0, 4'hF, `SI_ADDR_RANGE + 32'h100, '0);
        6:       issue(1'b1, 4'hF, SocBase, rnd);
        default: issue(1'b0, 4'hF, SocBase, '0);
      endcase
    end
    drain();
    check_value("boot_addr_o", boot_addr_o, boot_addr_m);
  endtask

  task automatic check_boot_straps();
    apply_reset(safety_island_pkg::BOOT_DEFAULT);
    issue(1'b0, 4'hF, SocBase + 8, '0);
    issue(1'b0, 4'hF, SocBase + 4, '0);
    drain();
    check_value("fetch_enable_o", {31'b0, fetch_enable_o}, 32'h0);
    apply_reset(safety_island_pkg::BOOT_JTAG);
    issue(1'b0, 4'hF, SocBase + 8, '0);
    issue(1'b0, 4'hF, SocBase + 4, '0);
    drain();
    check_value("fetch_enable_o", {31'b0, fetch_enable_o}, 32'h1);
  endtask

  // ----------------------------------------
  // Response compare and timeout
  // ----------------------------------------
  // Sampled mid-cycle; a request seen here answers two negedges later
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      req_hist = 2'b00;
    end else begin
      check_value("rvalid_o", {31'b0, rvalid_o}, {31'b0, req_hist[1]});
      if (req_hist[1]) begin
        resp_item = exp_q.pop_front();
        if (resp_item.is_read) check_value("rdata_o", rdata_o, resp_item.data);
      end
      req_hist = {req_hist[0], req_i.req};
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout after %0d cycles, the test sequence did not finish", cycle_cnt);
      $display("Something failed");
      $fatal(1, "Timeout");
    end
  end

  initial begin
    rst_ni         = 1'b0;
    req_i          = '0;
    bootmode_i     = safety_island_pkg::BOOT_DEFAULT;
    fetch_enable_i = 1'b0;
    apply_reset(safety_island_pkg::BOOT_DEFAULT);
    exercise_boot_regs();
    run_bank_traffic();
    read_boot_rom();
    probe_error_target();
    run_mixed_burst();
    check_boot_straps();
    $display("Everything OK");
    $finish;
  end

endmodule

// File: tb.f
+incdir+.
safety_island_pkg.sv
si_addr_decode.sv
si_mem_bank.sv
si_periph_block.sv
si_access_stage.sv
safety_island_top.sv
tb_safety_island.sv

// File: run.sh
#!/bin/sh
# Build the safety island testbench with Verilator and run it.
# Exit status 0 only when the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module tb_safety_island -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Everything OK" sim.log; then
  exit 0
fi
echo "Pass line not found in sim.log"
exit 1
